//--- program.hex
// Columns: 32-bit words in hex, several per line; an @ line sets the next word address
// Program from 0x00, throw vectors at 0x40, trampoline at 0x60, data at 0x70
@00
01000ED4 02000005 03000070                      // r1 = -300, r2 = 5, r3 = 0x70
23120003 23121003 23122003 23123003             // or and add mul, stored to [r3]
23125003 23126003 23127003 23128003             // shl lt eq ge
23129003 2312A003 2312B003 2312C003             // andn xor sub xnor
2312D003 2312E003 2312F003                      // shr ne sra
6312B064 A321B064 63125004 A3215007             // xiy sub, ixy sub, xiy shl, ixy shl
14002078 23402001                               // r4 = [0x78], store r4 + 1
0FF02001 23000BAD                               // Branch over a stray store
C0000002                                        // Throw through vector 2
@42
00000068                                        // Vector 2 points at the handler
@60
230006A6 1F00207F                               // Trap marker, return through the slot
@68
230005A5 0FF02FFF                               // Throw marker, then spin in place
@78
12345678                                        // Load operand
@7f
00000000                                        // Return address slot

//--- tb.f
isaPkg.sv
sysPkg.sv
regFile.sv
insnDecode.sv
execUnit.sv
cpuCore.sv
sysMemory.sv
cpuSystem.sv
tbCpu.sv

//--- runSim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tbCpu -o simCpu
./obj_dir/simCpu | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- tbCpu.sv
`timescale 1ns/10ps
`default_nettype none

module tbCpu
    import isaPkg::*, sysPkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 5;
    localparam int INSN_CYCLES    = 7;
    localparam int WATCHDOG_INSNS = 400;
    localparam int QUIET_INSNS    = 20;     // Window watched after halt
    localparam int NUM_TESTS      = 6;

    // Addresses and operands of the test program in program.hex
    localparam wordT DATA_ADDR  = 32'h0000_0070;
    localparam wordT LOAD_WORD  = 32'h1234_5678;
    localparam wordT X_VAL      = -32'sd300;   // r1
    localparam wordT Y_VAL      = 32'd5;       // r2
    localparam wordT THROW_PC   = 32'h0000_001a;
    localparam wordT SPIN_PC    = 32'h0000_0069;
    localparam wordT THROW_MARK = 32'h0000_05a5;
    localparam wordT TRAP_MARK  = 32'h0000_06a6;
    localparam wordT TRUE_WORD  = 32'hffff_ffff;

    logic clk;
    logic reset_n;
    logic trap;
    logic halt;
    logic busStrobe;
    logic busWrite;
    wordT busAddr;
    wordT busData;

    wordT       expAddr [32];
    wordT       expData [32];
    logic [4:0] expCount    = '0;
    logic [4:0] storeIdx    = '0;   // Next entry of the expected list
    logic       started     = 1'b0;
    int         errorCount  = 0;
    int         testsFailed = 0;

    cpuSystem u_cpuSystem (
        .clk       (clk),
        .reset_n   (reset_n),
        .trap      (trap),
        .halt      (halt),
        .busStrobe (busStrobe),
        .busWrite  (busWrite),
        .busAddr   (busAddr),
        .busData   (busData)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Whole program plus reset, with a wide margin
    initial begin
        #((RESET_CYCLES + WATCHDOG_INSNS * INSN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the program did not finish within %0d instruction times",
            WATCHDOG_INSNS);
        $display("CHECKS FAILED");
        $finish;
    end

    always @(posedge clk) begin
        started <= 1'b1;
        if (busStrobe && busWrite)
            storeIdx <= storeIdx + 5'd1;
    end

    // Reference model of the ALU, third operand added last
    function automatic wordT refAlu(opT op, wordT a, wordT b, wordT c);
        wordT r;
        case (op)
            opOr:    r = a | b;
            opAnd:   r = a & b;
            opAdd:   r = a + b;
            opMul:   r = a * b;
            opShl:   r = a << b;
            opLt:    r = ($signed(a) < $signed(b)) ? TRUE_WORD : '0;
            opEq:    r = (a == b) ? TRUE_WORD : '0;
            opGe:    r = ($signed(a) >= $signed(b)) ? TRUE_WORD : '0;
            opAndn:  r = a & ~b;
            opXor:   r = a ^ b;
            opSub:   r = a - b;
            opXnor:  r = ~(a ^ b);
            opShr:   r = a >> b;
            opNe:    r = (a != b) ? TRUE_WORD : '0;
            opSra:   r = $signed(a) >>> b;
            default: r = '0;
        endcase
        return r + c;
    endfunction

    task automatic expectStore(wordT addr, wordT data);
        expAddr[expCount] = addr;
        expData[expCount] = data;
        expCount = expCount + 5'd1;
    endtask

    task automatic reportTest(int num, string name, int errorsBefore);
        if (errorCount == errorsBefore) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed with %0d errors", num, name,
                errorCount - errorsBefore);
        end
    endtask

    // No bus cycle while reset or halt holds the core
    assert property (@(posedge clk) started && (!reset_n || halt) |-> !busStrobe)
        else begin
            errorCount++;
            $display("%0t: bus strobe seen while reset or halt was active", $time);
        end

    assert property (@(posedge clk) busStrobe && busWrite |-> storeIdx < expCount)
        else begin
            errorCount++;
            $display("%0t: unexpected store of %h to %h beyond the expected list",
                $time, $sampled(busData), $sampled(busAddr));
        end

    assert property (@(posedge clk) busStrobe && busWrite && storeIdx < expCount
        |-> busAddr == expAddr[storeIdx] && busData == expData[storeIdx])
        else begin
            errorCount++;
            $display("Mismatch at %0t: store %0d wrote %h to %h, expected %h to %h",
                $time, $sampled(storeIdx), $sampled(busData), $sampled(busAddr),
                expData[$sampled(storeIdx)], expAddr[$sampled(storeIdx)]);
        end

    initial begin
        int errorsBefore;

        reset_n = 1'b0;
        trap    = 1'b0;
        halt    = 1'b1;     // Hold the core in idle past reset

        // All xyi with r1, r2 and an immediate of three
        for (int k = 0; k < 16; k++) begin
            if (k != 4)
                expectStore(DATA_ADDR, refAlu(opT'(k[3:0]), X_VAL, Y_VAL, 32'd3));
        end
        expectStore(DATA_ADDR, refAlu(opSub, X_VAL, 32'd100, Y_VAL));  // xiy
        expectStore(DATA_ADDR, refAlu(opSub, 32'd100, Y_VAL, X_VAL));  // ixy
        expectStore(DATA_ADDR, refAlu(opShl, X_VAL, 32'd4, Y_VAL));
        expectStore(DATA_ADDR, refAlu(opShl, 32'd7, Y_VAL, X_VAL));
        expectStore(DATA_ADDR, LOAD_WORD + 32'd1);
        expectStore(TRAP_ADDR, THROW_PC);
        expectStore(DATA_ADDR, THROW_MARK);
        expectStore(TRAP_ADDR, SPIN_PC);
        expectStore(DATA_ADDR, TRAP_MARK);

        errorsBefore = errorCount;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        repeat (4) @(negedge clk);
        halt = 1'b0;
        reportTest(1, "quiet bus in reset and idle", errorsBefore);

        errorsBefore = errorCount;
        wait (storeIdx == 5'd15);
        @(negedge clk);
        reportTest(2, "fifteen ALU operations", errorsBefore);

        errorsBefore = errorCount;
        wait (storeIdx == 5'd19);
        @(negedge clk);
        reportTest(3, "operand kinds", errorsBefore);

        errorsBefore = errorCount;
        wait (storeIdx == 5'd20);
        @(negedge clk);
        reportTest(4, "load and branch", errorsBefore);

        // Trap lands on the spin loop right after the throw marker
        errorsBefore = errorCount;
        wait (storeIdx == 5'd22);
        @(negedge clk);
        trap = 1'b1;
        wait (storeIdx == 5'd23);
        @(negedge clk);
        trap = 1'b0;
        wait (storeIdx == 5'd24);
        @(negedge clk);
        halt = 1'b1;        // Taken at the next s0
        reportTest(5, "throw and trap", errorsBefore);

        errorsBefore = errorCount;
        repeat (QUIET_INSNS * INSN_CYCLES) @(negedge clk);
        reportTest(6, "halt keeps the bus quiet", errorsBefore);

        $display("%0d of %0d tests passed, %0d of %0d stores seen, %0d errors",
            NUM_TESTS - testsFailed, NUM_TESTS, storeIdx, expCount, errorCount);
        if (errorCount == 0 && testsFailed == 0 && storeIdx == expCount) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cpuSystem.sv
`timescale 1ns/10ps
`default_nettype none

module cpuSystem
    import isaPkg::*;
(
    input  wire  clk,
    input  wire  reset_n,
    input  wire  trap,
    input  wire  halt,
    output logic busStrobe,
    output logic busWrite,
    output wordT busAddr,
    output wordT busData
);

    wordT iAddr;
    wordT iData;
    wordT dIn;

    cpuCore u_cpuCore (
        .clk      (clk),
        .reset_n  (reset_n),
        .trap     (trap),
        .halt     (halt),
        .iAddr    (iAddr),
        .iData    (iData),
        .strobe   (busStrobe),  // Data bus is visible at the top
        .memWrite (busWrite),
        .dAddr    (busAddr),
        .dOut     (busData),
        .dIn      (dIn)
    );

    sysMemory u_sysMemory (
        .clk      (clk),
        .strobe   (busStrobe),
        .memWrite (busWrite),
        .iAddr    (iAddr),
        .dAddr    (busAddr),
        .dOut     (busData),
        .iData    (iData),
        .dIn      (dIn)
    );

endmodule

`default_nettype wire

//--- sysMemory.sv
`timescale 1ns/10ps
`default_nettype none

module sysMemory
    import isaPkg::*, sysPkg::*;
(
    input  wire       clk,
    input  wire       strobe,
    input  wire       memWrite,
    input  wire wordT iAddr,
    input  wire wordT dAddr,
    input  wire wordT dOut,
    output wordT      iData,
    output wordT      dIn
);

    wordT   mem [MEM_WORDS];
    memIdxT iIdx;
    memIdxT dIdx;

    // Upper address bits wrap
    assign iIdx = iAddr[MEM_ADDR_BITS-1:0];
    assign dIdx = dAddr[MEM_ADDR_BITS-1:0];

    // Program, vector table, trampoline and data
    initial begin
        $readmemh("program.hex", mem);
    end

    // Both read ports answer one clock after the address
    always_ff @(posedge clk) begin
        iData <= mem[iIdx];
        dIn   <= mem[dIdx];     // Old contents on a same-cycle write
    end

    always_ff @(posedge clk) begin
        if (strobe && memWrite)
            mem[dIdx] <= dOut;
    end

endmodule

`default_nettype wire

//--- cpuCore.sv
`timescale 1ns/10ps
`default_nettype none

module cpuCore
    import isaPkg::*, sysPkg::*;
(
    input  wire       clk,
    input  wire       reset_n,
    input  wire       trap,
    input  wire       halt,
    output wordT      iAddr,
    input  wire wordT iData,
    output logic      strobe,
    output logic      memWrite,
    output wordT      dAddr,
    output wordT      dOut,
    input  wire wordT dIn
);

    coreStateT state;
    coreStateT stateNext;
    insnT      insn;        // Current instruction
    decodedT   dec;
    wordT      aluReg;      // ALU result, later the saved return address
    wordT      loadData;
    wordT      nextPc;
    wordT      vecAddr;     // Target of a pending trap or throw
    wordT      aluOut;
    wordT      valX;
    wordT      valY;
    wordT      valZ;
    wordT      nextZ;
    logic      regWrite;

    always_comb begin
        case (state)
            idle:    stateNext = halt ? idle : s5;
            s0: begin
                if (halt)
                    stateNext = idle;
                else if (trap)
                    stateNext = trapF;
                else if (dec.throw)
                    stateNext = throwE;
                else
                    stateNext = s1;
            end
            s1:      stateNext = s2;
            s2:      stateNext = s3;    // Slack for the multiplier
            s3:      stateNext = s4;
            s4:      stateNext = s5;
            s5:      stateNext = s6;
            s6:      stateNext = s0;
            throwE:  stateNext = vecR;
            trapF:   stateNext = saveT;
            vecR:    stateNext = saveT;
            saveT:   stateNext = jumpW;
            jumpW:   stateNext = s5;
            default: stateNext = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n)
            state <= idle;
        else
            state <= stateNext;
    end

    always_ff @(posedge clk) begin
        case (state)
            idle:    iAddr    <= RESET_VECTOR;
            s1:      aluReg   <= aluOut;
            s3:      loadData <= dIn;
            s4:      iAddr    <= dec.branch ? nextZ : nextPc;
            s5:      nextPc   <= iAddr + 1;
            s6:      insn     <= iData;     // Fetch data lands one cycle after s5
            trapF:   vecAddr  <= TRAMP_BOTTOM;
            vecR:    vecAddr  <= dIn;
            saveT:   aluReg   <= iAddr;     // Address of the interrupted instruction
            jumpW:   iAddr    <= vecAddr;
            default: ;
        endcase
    end

    insnDecode u_insnDecode (
        .insn (insn),
        .dec  (dec)
    );

    execUnit u_execUnit (
        .clk    (clk),
        .en     (state == s0),
        .op     (dec.op),
        .kind   (dec.kind),
        .valX   (valX),
        .valY   (valY),
        .imm    (dec.imm),
        .result (aluOut)
    );

    // Memory controls
    always_comb begin
        strobe   = (state == s3 && (dec.storing || dec.derefRhs)) || state == jumpW;
        memWrite = (state == s3 && dec.storing) || state == jumpW;

        if (state == jumpW)
            dAddr = TRAP_ADDR;
        else if (state == throwE || state == vecR)
            dAddr = VECTOR_ADDR | wordT'(dec.vector);
        else if (dec.derefRhs)
            dAddr = aluReg;
        else
            dAddr = valZ;

        dOut = (dec.derefRhs && state != jumpW) ? valZ : aluReg;
    end

    assign nextZ    = dec.derefRhs ? loadData : aluReg;
    assign regWrite = state == s4 && !dec.storing && !dec.branch && dec.z != ZERO_IDX;

    regFile u_regFile (
        .clk       (clk),
        .writeEn   (regWrite),
        .writeIdx  (dec.z),
        .readIdxX  (dec.x),
        .readIdxY  (dec.y),
        .writeData (nextZ),
        .nextPc    (nextPc),
        .valZ      (valZ),
        .valX      (valX),
        .valY      (valY)
    );

    // Strobe is a single-cycle pulse in s3 or jumpW
    assert property (@(posedge clk) disable iff (!reset_n)
        strobe |-> state inside {s3, jumpW} ##1 !strobe)
        else $error("strobe outside s3 and jumpW");

endmodule

`default_nettype wire

//--- execUnit.sv
`timescale 1ns/10ps
`default_nettype none

module execUnit
    import isaPkg::*;
(
    input  wire       clk,
    input  wire       en,
    input  wire opT   op,
    input  wire kindT kind,
    input  wire wordT valX,
    input  wire wordT valY,
    input  wire wordT imm,
    output wordT      result
);

    logic signed [WORD_BITS-1:0] a;
    logic signed [WORD_BITS-1:0] b;
    logic signed [WORD_BITS-1:0] c;
    wordT                        opResult;

    // Operand shuffle
    always_comb begin
        case (kind)
            kindXiy: begin
                a = valX;
                b = imm;
                c = valY;
            end
            kindIxy: begin
                a = imm;
                b = valX;
                c = valY;
            end
            default: begin      // xyi, throw result is discarded
                a = valX;
                b = valY;
                c = imm;
            end
        endcase
    end

    always_comb begin
        case (op)
            opOr:    opResult = a | b;
            opAnd:   opResult = a & b;
            opAdd:   opResult = a + b;
            opMul:   opResult = a * b;
            opShl:   opResult = a << b;
            opLt:    opResult = {WORD_BITS{a < b}};     // All ones when true
            opEq:    opResult = {WORD_BITS{a == b}};
            opGe:    opResult = {WORD_BITS{a >= b}};
            opAndn:  opResult = a & ~b;
            opXor:   opResult = a ^ b;
            opSub:   opResult = a - b;
            opXnor:  opResult = a ~^ b;
            opShr:   opResult = a >> b;
            opNe:    opResult = {WORD_BITS{a != b}};
            opSra:   opResult = a >>> b;
            default: opResult = 'x;                     // Reserved opcode
        endcase
    end

    always_ff @(posedge clk) begin
        if (en)
            result <= opResult + c;
    end

endmodule

`default_nettype wire

//--- insnDecode.sv
`timescale 1ns/10ps
`default_nettype none

module insnDecode
    import isaPkg::*;
(
    input  wire insnT insn,
    output decodedT   dec
);

    always_comb begin
        dec.z        = insn.z;
        dec.x        = insn.x;
        dec.y        = insn.y;
        dec.op       = insn.op;
        dec.kind     = insn.kind;
        dec.storing  = insn.storing;
        dec.derefRhs = insn.derefRhs;

        dec.imm = {{(WORD_BITS-IMM_BITS){insn.imm[IMM_BITS-1]}}, insn.imm};

        // Kind three never reaches the ALU result path
        dec.throw = (insn.kind == kindThrow);

        // Writing the PC without a store is a jump
        dec.branch = (insn.z == PC_IDX) && !insn.storing;

        dec.vector = insn[VEC_BITS-1:0];    // Shares bits with the immediate
    end

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile
    import isaPkg::*;
(
    input  wire         clk,
    input  wire         writeEn,
    input  wire regIdxT writeIdx,   // Also selects valZ
    input  wire regIdxT readIdxX,
    input  wire regIdxT readIdxY,
    input  wire wordT   writeData,
    input  wire wordT   nextPc,
    output wordT        valZ,
    output wordT        valX,
    output wordT        valY
);

    wordT regs [1:14];      // No storage behind r0 and the PC

    function automatic wordT readReg(regIdxT idx);
        if (idx == ZERO_IDX)
            return '0;
        if (idx == PC_IDX)
            return nextPc;
        return regs[idx];
    endfunction

    assign valZ = readReg(writeIdx);
    assign valX = readReg(readIdxX);
    assign valY = readReg(readIdxY);

    always_ff @(posedge clk) begin
        if (writeEn && writeIdx != ZERO_IDX && writeIdx != PC_IDX)
            regs[writeIdx] <= writeData;
    end

    // The core filters r0 destinations before requesting a commit
    assert property (@(posedge clk) writeEn |-> writeIdx != ZERO_IDX)
        else $error("commit requested for register 0");

endmodule

`default_nettype wire

//--- sysPkg.sv
`default_nettype none

package sysPkg;

    import isaPkg::*;

    // Memory map
    localparam wordT RESET_VECTOR = 32'h0000_0000;
    localparam wordT VECTOR_ADDR  = 32'h0000_0040;  // Throw vector table
    localparam wordT TRAMP_BOTTOM = 32'h0000_0060;  // Trap trampoline entry
    localparam wordT TRAP_ADDR    = 32'h0000_007f;  // Return address slot

    localparam int MEM_WORDS     = 128;
    localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);

    typedef logic [MEM_ADDR_BITS-1:0] memIdxT;

    typedef enum logic [3:0] {
        idle,
        s0, s1, s2, s3, s4, s5, s6,
        throwE, trapF, vecR, saveT, jumpW
    } coreStateT;

endpackage

`default_nettype wire

//--- isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int WORD_BITS = 32;
    localparam int REG_BITS  = 4;
    localparam int IMM_BITS  = 12;
    localparam int VEC_BITS  = 5;

    typedef logic [WORD_BITS-1:0] wordT;    // Data and address word
    typedef logic [REG_BITS-1:0]  regIdxT;  // 0 reads as zero, 15 is the PC
    typedef logic [IMM_BITS-1:0]  immT;
    typedef logic [VEC_BITS-1:0]  vecT;     // Throw vector number

    localparam regIdxT ZERO_IDX = 4'h0;
    localparam regIdxT PC_IDX   = 4'hf;

    typedef enum logic [3:0] {
        opOr, opAnd, opAdd, opMul, opRsvd, opShl, opLt, opEq,
        opGe, opAndn, opXor, opSub, opXnor, opShr, opNe, opSra
    } opT;

    typedef enum logic [1:0] {
        kindXyi,    // A=X B=Y C=I
        kindXiy,    // A=X B=I C=Y
        kindIxy,    // A=I B=X C=Y
        kindThrow
    } kindT;

    // Instruction word, high bits first
    typedef struct packed {
        kindT   kind;
        logic   storing;
        logic   derefRhs;
        regIdxT z;
        regIdxT x;
        regIdxT y;
        opT     op;
        immT    imm;
    } insnT;

    typedef struct packed {
        regIdxT z;
        regIdxT x;
        regIdxT y;
        opT     op;
        kindT   kind;
        wordT   imm;        // Sign-extended
        logic   storing;
        logic   derefRhs;
        logic   throw;
        logic   branch;
        vecT    vector;
    } decodedT;

endpackage

`default_nettype wire
